//--- Makefile
VERILATOR ?= verilator
TOP       ?= dma_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --assert -j 0
FLIST     ?= tb.f

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
HDRS := $(wildcard logic/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FLIST) $(SRCS) $(HDRS)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf $(OBJ_DIR)

//--- logic/dma_bus_pkg.sv
`include "dma_settings.svh"

package dma_bus_pkg;

    // slave byte address, bit 7 picks descriptor space
    typedef logic [7:0] cfg_addr_t;
    // data word on both buses
    typedef logic [31:0] bus_data_t;
    // byte lane enables
    typedef logic [3:0] bus_sel_t;
    // memory byte address, word address plus two lane bits
    typedef logic [`DMA_WADDR_BITS+1:0] mem_addr_t;

endpackage

//--- logic/dma_byte_packer.sv
module dma_byte_packer (
    input  logic                   fast_clk_i,
    input  logic                   dma_engine_reset,
    input  dma_bus_pkg::bus_data_t mem_dat_i,
    output logic [7:0]             tx_data_o,
    output logic                   tx_valid_o,
    input  logic                   tx_ready_i,
    input  logic [7:0]             rx_data_i,
    input  logic                   rx_valid_i,
    output logic                   rx_ready_o,
    dma_ctrl_if.pack               ctrl,
    dma_lane_if.pack               lane
);
    import dma_bus_pkg::*;
    import dma_desc_pkg::*;

    bus_data_t word_q;
    lane_t     cur_lane_q;
    logic      active_q;
    logic      last_lane;
    logic      xfer;

    // byte mode moves a single lane
    assign last_lane = ctrl.byte_mode || (cur_lane_q == 2'd3);

    // to-stream offers bytes, from-stream takes them
    assign tx_valid_o = active_q && !ctrl.dir;
    assign rx_ready_o = active_q && ctrl.dir;
    assign xfer       = (tx_valid_o && tx_ready_i) || (rx_ready_o && rx_valid_i);

    always_ff @(posedge fast_clk_i) begin
        if (dma_engine_reset) begin
            active_q   <= 1'b0;
            cur_lane_q <= '0;
        end else if (lane.go) begin
            active_q   <= 1'b1;
            cur_lane_q <= ctrl.byte_mode ? ctrl.lane : lane_t'(0);
        end else if (xfer) begin
            if (last_lane) begin
                active_q <= 1'b0;
            end else begin
                cur_lane_q <= cur_lane_q + 1'b1;
            end
        end
    end

    // read data on load, else fill the current lane from rx
    always_ff @(posedge fast_clk_i) begin
        if (lane.load) begin
            word_q <= mem_dat_i;
        end else if (rx_ready_o && rx_valid_i) begin
            word_q[{cur_lane_q, 3'b000} +: 8] <= rx_data_i;
        end
    end

    assign tx_data_o = word_q[{cur_lane_q, 3'b000} +: 8];

    assign lane.word     = word_q;
    assign lane.finished = xfer && last_lane;

endmodule

//--- logic/dma_ctrl_if.sv
interface dma_ctrl_if;
    import dma_desc_pkg::*;

    // configuration from the register block
    logic       dir;
    logic       byte_mode;
    lane_t      lane;
    // one cycle start pulse
    logic       start;
    // descriptor at desc_idx
    desc_word_t desc_word;

    // status back from the sequencer
    desc_idx_t  desc_idx;
    logic       busy;
    logic       run_done;

    modport decode (output dir, byte_mode, lane, start, desc_word,
                    input  desc_idx, busy, run_done);
    modport seq    (input  dir, byte_mode, lane, start, desc_word,
                    output desc_idx, busy, run_done);
    // packer only needs the lane setup
    modport pack   (input  dir, byte_mode, lane);

endinterface

//--- logic/dma_desc_pkg.sv
`include "dma_settings.svh"

package dma_desc_pkg;

    // descriptor word
    // 17:0 word address, 18 increment, 30:19 length, 31 last
    typedef logic [31:0] desc_word_t;

    // fields pulled out of a descriptor
    typedef logic [`DMA_WADDR_BITS-1:0] word_addr_t;
    typedef logic [`DMA_LEN_BITS-1:0]   desc_len_t;

    // slot number in the descriptor table
    typedef logic [$clog2(`DMA_DESC_COUNT)-1:0] desc_idx_t;

    // byte lane inside a data word
    typedef logic [1:0] lane_t;

    // sequencer states
    typedef enum logic [2:0] {
        IDLE,
        DECODE,
        BYTES,
        ACCESS,
        NEXT,
        DONE
    } seq_state_t;

endpackage

//--- logic/dma_lane_if.sv
interface dma_lane_if;
    import dma_bus_pkg::*;

    // start of a byte phase
    logic      go;
    // capture memory read data into the word register
    logic      load;
    // word register, also the memory write data
    bus_data_t word;
    // last byte of the phase done
    logic      finished;

    modport seq  (output go, load,
                  input  finished);
    modport pack (input  go, load,
                  output word, finished);

endinterface

//--- logic/dma_reg_decode.sv
`include "dma_settings.svh"

module dma_reg_decode (
    input  logic                   fast_clk_i,
    input  logic                   dma_engine_reset,
    input  logic                   cfg_cyc_i,
    input  logic                   cfg_stb_i,
    input  logic                   cfg_we_i,
    input  dma_bus_pkg::cfg_addr_t cfg_adr_i,
    input  dma_bus_pkg::bus_data_t cfg_dat_i,
    input  dma_bus_pkg::bus_sel_t  cfg_sel_i,
    output dma_bus_pkg::bus_data_t cfg_dat_o,
    output logic                   cfg_ack_o,
    input  logic                   dma_req_i,
    output logic                   dma_rdy_o,
    dma_ctrl_if.decode             ctrl
);
    import dma_bus_pkg::*;
    import dma_desc_pkg::*;

    // control word bits
    logic       enable_q;
    logic       allow_q;
    logic       dir_q;
    logic       byte_mode_q;
    lane_t      lane_q;

    logic       ack_q;
    bus_data_t  rdata_q;
    bus_data_t  run_count_q;
    desc_word_t desc_mem [`DMA_DESC_COUNT];

    logic       ctl_wr;
    logic [1:0] word_sel;
    desc_idx_t  slot_idx;
    logic       soft_trig;
    bus_data_t  ctrl_word;
    bus_data_t  rd_mux;

    // control space writes, word number in bits 3:2
    assign ctl_wr   = cfg_cyc_i && cfg_stb_i && cfg_we_i && !cfg_adr_i[7];
    assign word_sel = cfg_adr_i[3:2];
    assign slot_idx = cfg_adr_i[6:2];

    // soft trigger is bit 3 of the trigger word
    assign soft_trig = ctl_wr && (word_sel == 2'(`DMA_REG_TRIG)) && cfg_sel_i[0]
                       && cfg_dat_i[3];

    // only fires while idle, so one pulse per run
    assign ctrl.start = enable_q && !ctrl.busy && (soft_trig || (allow_q && dma_req_i));

    always_ff @(posedge fast_clk_i) begin
        if (dma_engine_reset) begin
            enable_q    <= 1'b0;
            allow_q     <= 1'b0;
            dir_q       <= 1'b0;
            byte_mode_q <= 1'b0;
            lane_q      <= '0;
        end else if (ctl_wr && (word_sel == 2'(`DMA_REG_CTRL)) && cfg_sel_i[0]) begin
            enable_q    <= cfg_dat_i[0];
            allow_q     <= cfg_dat_i[2];
            dir_q       <= cfg_dat_i[3];
            byte_mode_q <= cfg_dat_i[5];
            lane_q      <= cfg_dat_i[7:6];
        end
    end

    // run counter, any write to its word clears it
    always_ff @(posedge fast_clk_i) begin
        if (dma_engine_reset) begin
            run_count_q <= '0;
        end else if (ctl_wr && (word_sel == 2'(`DMA_REG_RUNS))) begin
            run_count_q <= '0;
        end else if (ctrl.run_done) begin
            run_count_q <= run_count_q + 1'b1;
        end
    end

    // descriptor table, byte enabled
    always_ff @(posedge fast_clk_i) begin
        for (int b = 0; b < 4; b++) begin
            if (cfg_cyc_i && cfg_stb_i && cfg_we_i && cfg_adr_i[7] && cfg_sel_i[b]) begin
                desc_mem[slot_idx][8*b +: 8] <= cfg_dat_i[8*b +: 8];
            end
        end
    end

    assign ctrl_word = {24'd0, lane_q, byte_mode_q, 1'b0, dir_q, allow_q, ctrl.busy, enable_q};

    always_comb begin
        rd_mux = '0;
        if (cfg_adr_i[7]) begin
            rd_mux = desc_mem[slot_idx];
        end else begin
            case (word_sel)
                2'(`DMA_REG_CTRL): rd_mux = ctrl_word;
                2'(`DMA_REG_DESC): rd_mux = bus_data_t'(ctrl.desc_idx);
                2'(`DMA_REG_RUNS): rd_mux = run_count_q;
                // trigger word reads back zero
                default:           rd_mux = '0;
            endcase
        end
    end

    // ack one cycle after the request, read data registered with it
    always_ff @(posedge fast_clk_i) begin
        if (dma_engine_reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= cfg_cyc_i && cfg_stb_i;
        end
    end

    always_ff @(posedge fast_clk_i) begin
        rdata_q <= rd_mux;
    end

    assign cfg_ack_o = ack_q;
    assign cfg_dat_o = rdata_q;

    // setup toward the engine
    assign ctrl.dir       = dir_q;
    assign ctrl.byte_mode = byte_mode_q;
    assign ctrl.lane      = lane_q;
    assign ctrl.desc_word = desc_mem[ctrl.desc_idx];

    assign dma_rdy_o = enable_q && allow_q && !ctrl.busy;

endmodule

//--- logic/dma_sequencer.sv
`include "dma_settings.svh"

module dma_sequencer (
    input  logic                   fast_clk_i,
    input  logic                   dma_engine_reset,
    output logic                   mem_cyc_o,
    output logic                   mem_stb_o,
    output logic                   mem_we_o,
    output dma_bus_pkg::mem_addr_t mem_adr_o,
    output dma_bus_pkg::bus_sel_t  mem_sel_o,
    input  logic                   mem_ack_i,
    dma_ctrl_if.seq                ctrl,
    dma_lane_if.seq                lane
);
    import dma_bus_pkg::*;
    import dma_desc_pkg::*;

    seq_state_t state_q;
    desc_idx_t  idx_q;
    desc_len_t  cnt_q;
    word_addr_t addr_q;

    // fields of the current descriptor
    word_addr_t d_addr;
    logic       d_incr;
    desc_len_t  d_len;
    logic       d_last;
    logic       cnt_end;

    assign d_addr  = ctrl.desc_word[`DMA_WADDR_BITS-1:0];
    assign d_incr  = ctrl.desc_word[`DMA_WADDR_BITS];
    assign d_len   = ctrl.desc_word[`DMA_WADDR_BITS+1 +: `DMA_LEN_BITS];
    assign d_last  = ctrl.desc_word[31];
    // transfer count is length plus one
    assign cnt_end = (cnt_q == d_len);

    always_ff @(posedge fast_clk_i) begin
        if (dma_engine_reset) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE:    if (ctrl.start) state_q <= DECODE;
                // to-stream reads first, from-stream collects bytes first
                DECODE:  state_q <= ctrl.dir ? BYTES : ACCESS;
                BYTES:   if (lane.finished) state_q <= ctrl.dir ? ACCESS : NEXT;
                ACCESS:  if (mem_ack_i) state_q <= ctrl.dir ? NEXT : BYTES;
                NEXT:    state_q <= (cnt_end && d_last) ? DONE : DECODE;
                DONE:    state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // transfer count and descriptor walk
    always_ff @(posedge fast_clk_i) begin
        if (dma_engine_reset || (state_q == IDLE && ctrl.start)) begin
            idx_q <= '0;
            cnt_q <= '0;
        end else if (state_q == NEXT) begin
            if (cnt_end) begin
                cnt_q <= '0;
                idx_q <= idx_q + 1'b1;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // word address for this transfer
    always_ff @(posedge fast_clk_i) begin
        if (state_q == DECODE) begin
            addr_q <= d_incr ? d_addr + word_addr_t'(cnt_q) : d_addr;
        end
    end

    // access held up until ack
    assign mem_cyc_o = (state_q == ACCESS);
    assign mem_stb_o = mem_cyc_o;
    assign mem_we_o  = mem_cyc_o && ctrl.dir;
    assign mem_adr_o = {addr_q, 2'b00};

    // one lane in byte mode
    always_comb begin
        if (ctrl.byte_mode) begin
            mem_sel_o = bus_sel_t'(1) << ctrl.lane;
        end else begin
            mem_sel_o = '1;
        end
    end

    // byte phase kicks off on entry to BYTES
    assign lane.go   = (state_q == DECODE && ctrl.dir)
                       || (state_q == ACCESS && mem_ack_i && !ctrl.dir);
    assign lane.load = (state_q == ACCESS) && mem_ack_i && !ctrl.dir;

    assign ctrl.busy     = (state_q != IDLE);
    assign ctrl.run_done = (state_q == DONE);
    assign ctrl.desc_idx = idx_q;

endmodule

//--- logic/dma_settings.svh
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

// number of descriptor slots in the table
`define DMA_DESC_COUNT 32
// memory word address and descriptor length widths
`define DMA_WADDR_BITS 18
`define DMA_LEN_BITS   12

// control space word numbers, taken from address bits 3:2
`define DMA_REG_CTRL 0
`define DMA_REG_TRIG 1
`define DMA_REG_DESC 2
`define DMA_REG_RUNS 3

`endif

//--- logic/spi_dma_top.sv
module spi_dma_top (
    input  logic                   fast_clk_i,
    input  logic                   dma_engine_reset,
    // register slave
    input  logic                   cfg_cyc_i,
    input  logic                   cfg_stb_i,
    input  logic                   cfg_we_i,
    input  dma_bus_pkg::cfg_addr_t cfg_adr_i,
    input  dma_bus_pkg::bus_data_t cfg_dat_i,
    input  dma_bus_pkg::bus_sel_t  cfg_sel_i,
    output dma_bus_pkg::bus_data_t cfg_dat_o,
    output logic                   cfg_ack_o,
    // external request
    input  logic                   dma_req_i,
    output logic                   dma_rdy_o,
    // memory master
    output logic                   mem_cyc_o,
    output logic                   mem_stb_o,
    output logic                   mem_we_o,
    output dma_bus_pkg::mem_addr_t mem_adr_o,
    output dma_bus_pkg::bus_sel_t  mem_sel_o,
    output dma_bus_pkg::bus_data_t mem_dat_o,
    input  dma_bus_pkg::bus_data_t mem_dat_i,
    input  logic                   mem_ack_i,
    // byte streams
    output logic [7:0]             tx_data_o,
    output logic                   tx_valid_o,
    input  logic                   tx_ready_i,
    input  logic [7:0]             rx_data_i,
    input  logic                   rx_valid_i,
    output logic                   rx_ready_o
);

    dma_ctrl_if u_ctrl_if ();
    dma_lane_if u_lane_if ();

    dma_reg_decode u_decode (
        .fast_clk_i       (fast_clk_i),
        .dma_engine_reset (dma_engine_reset),
        .cfg_cyc_i        (cfg_cyc_i),
        .cfg_stb_i        (cfg_stb_i),
        .cfg_we_i         (cfg_we_i),
        .cfg_adr_i        (cfg_adr_i),
        .cfg_dat_i        (cfg_dat_i),
        .cfg_sel_i        (cfg_sel_i),
        .cfg_dat_o        (cfg_dat_o),
        .cfg_ack_o        (cfg_ack_o),
        .dma_req_i        (dma_req_i),
        .dma_rdy_o        (dma_rdy_o),
        .ctrl             (u_ctrl_if)
    );

    dma_sequencer u_seq (
        .fast_clk_i       (fast_clk_i),
        .dma_engine_reset (dma_engine_reset),
        .mem_cyc_o        (mem_cyc_o),
        .mem_stb_o        (mem_stb_o),
        .mem_we_o         (mem_we_o),
        .mem_adr_o        (mem_adr_o),
        .mem_sel_o        (mem_sel_o),
        .mem_ack_i        (mem_ack_i),
        .ctrl             (u_ctrl_if),
        .lane             (u_lane_if)
    );

    dma_byte_packer u_pack (
        .fast_clk_i       (fast_clk_i),
        .dma_engine_reset (dma_engine_reset),
        .mem_dat_i        (mem_dat_i),
        .tx_data_o        (tx_data_o),
        .tx_valid_o       (tx_valid_o),
        .tx_ready_i       (tx_ready_i),
        .rx_data_i        (rx_data_i),
        .rx_valid_i       (rx_valid_i),
        .rx_ready_o       (rx_ready_o),
        .ctrl             (u_ctrl_if),
        .lane             (u_lane_if)
    );

    // packer word register is the write data
    assign mem_dat_o = u_lane_if.word;

endmodule

//--- sim/dma_chk.sv
module dma_chk (
    input logic                   fast_clk_i,
    input logic                   dma_engine_reset,
    input logic                   mem_cyc_o,
    input logic                   mem_stb_o,
    input logic                   mem_we_o,
    input dma_bus_pkg::mem_addr_t mem_adr_o,
    input dma_bus_pkg::bus_sel_t  mem_sel_o,
    input logic                   mem_ack_i,
    input logic [7:0]             tx_data_o,
    input logic                   tx_valid_o,
    input logic                   tx_ready_i,
    input logic                   cfg_cyc_i,
    input logic                   cfg_stb_i,
    input logic                   cfg_ack_o
);
    // strobe and cycle move together
    a_stb_cyc: assert property (@(posedge fast_clk_i) disable iff (dma_engine_reset)
        mem_stb_o == mem_cyc_o) else $error("mem_stb_o differs from mem_cyc_o");

    // request held until ack
    a_mem_hold: assert property (@(posedge fast_clk_i) disable iff (dma_engine_reset)
        mem_cyc_o && !mem_ack_i |=> mem_cyc_o && $stable(mem_adr_o)
        && $stable(mem_sel_o) && $stable(mem_we_o))
        else $error("memory request changed before ack");

    a_tx_hold: assert property (@(posedge fast_clk_i) disable iff (dma_engine_reset)
        tx_valid_o && !tx_ready_i |=> tx_valid_o && $stable(tx_data_o))
        else $error("tx byte changed while stalled");

    // one cycle ack latency
    a_cfg_ack: assert property (@(posedge fast_clk_i) disable iff (dma_engine_reset)
        cfg_ack_o == $past(cfg_cyc_i && cfg_stb_i))
        else $error("cfg_ack_o does not follow the request by one cycle");

endmodule

bind spi_dma_top dma_chk u_chk (.*);

//--- sim/dma_tb.sv
module dma_tb;
    import dma_bus_pkg::*;

    // control space byte addresses
    localparam cfg_addr_t CTRL_ADR = 8'h00;
    localparam cfg_addr_t TRIG_ADR = 8'h04;
    localparam cfg_addr_t DESC_ADR = 8'h08;
    localparam cfg_addr_t RUNS_ADR = 8'h0C;
    localparam int ROWS = 5;
    // worst case per row is 6 transfers of 40 cycles plus register traffic
    localparam int LIMIT = ROWS * (6 * 40 + 400) + 1000;

    // one scenario per row with the expected counts at the end
    typedef struct packed {
        logic        dir;
        logic        bmode;
        logic [1:0]  lane;
        logic        ext;
        logic [1:0]  ndesc;
        logic [17:0] a0;
        logic        i0;
        logic [11:0] l0;
        logic [17:0] a1;
        logic        i1;
        logic [11:0] l1;
        logic [7:0]  exp_xfers;
        logic [7:0]  exp_bytes;
    } row_t;

    logic        fast_clk_i;
    logic        dma_engine_reset;
    logic        cfg_cyc_i;
    logic        cfg_stb_i;
    logic        cfg_we_i;
    cfg_addr_t   cfg_adr_i;
    bus_data_t   cfg_dat_i;
    bus_sel_t    cfg_sel_i;
    bus_data_t   cfg_dat_o;
    logic        cfg_ack_o;
    logic        dma_req_i;
    logic        dma_rdy_o;
    logic        mem_cyc_o;
    logic        mem_stb_o;
    logic        mem_we_o;
    mem_addr_t   mem_adr_o;
    bus_sel_t    mem_sel_o;
    bus_data_t   mem_dat_o;
    bus_data_t   mem_dat_i = '0;
    logic        mem_ack_i = 1'b0;
    logic [7:0]  tx_data_o;
    logic        tx_valid_o;
    logic        tx_ready_i = 1'b0;
    logic [7:0]  rx_data_i = 8'h00;
    logic        rx_valid_i = 1'b0;
    logic        rx_ready_o;

    row_t        table_q [ROWS];
    int          val_errs;
    int          misc_errs;
    int          cycles;
    int          ack_wait;
    logic [7:0]  rx_next;
    // access and stream logs
    mem_addr_t   log_adr [$];
    logic        log_we [$];
    bus_sel_t    log_sel [$];
    bus_data_t   log_dat [$];
    logic [7:0]  tx_log [$];
    logic [7:0]  rx_log [$];

    dma_tb_clk u_clk (.fast_clk_o(fast_clk_i));

    spi_dma_top i_dut (.*);

    // memory contents come from the address
    function automatic bus_data_t model_word(input mem_addr_t adr);
        return bus_data_t'(adr) ^ 32'h5A3C_96E1;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        val_errs++;
        $display("ERROR %s expected %h got %h", name, exp, got);
    endtask

    // memory slave acks after 0 to 3 wait cycles
    always @(negedge fast_clk_i) begin
        if (mem_ack_i) begin
            mem_ack_i = 1'b0;
        end else if (mem_cyc_o) begin
            if (ack_wait == 0) begin
                mem_ack_i = 1'b1;
                mem_dat_i = model_word(mem_adr_o);
                log_adr.push_back(mem_adr_o);
                log_we.push_back(mem_we_o);
                log_sel.push_back(mem_sel_o);
                log_dat.push_back(mem_dat_o);
                ack_wait = $urandom % 4;
            end else begin
                ack_wait--;
            end
        end
    end

    // tx sink with random gaps
    // a logged byte moves at the next rising edge
    always @(negedge fast_clk_i) begin
        tx_ready_i = ($urandom % 4) != 0;
        if (tx_valid_o && tx_ready_i) begin
            tx_log.push_back(tx_data_o);
        end
    end

    // rx source
    always @(negedge fast_clk_i) begin
        rx_valid_i = ($urandom % 4) != 0;
        rx_data_i  = rx_next;
        if (rx_ready_o && rx_valid_i) begin
            rx_log.push_back(rx_next);
            rx_next = 8'($urandom);
        end
    end

    always @(posedge fast_clk_i) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic cfg_access(input logic we, input cfg_addr_t adr, input bus_data_t dat,
                              output bus_data_t rdata);
        @(negedge fast_clk_i);
        cfg_cyc_i = 1'b1;
        cfg_stb_i = 1'b1;
        cfg_we_i  = we;
        cfg_adr_i = adr;
        cfg_dat_i = dat;
        cfg_sel_i = 4'hF;
        @(negedge fast_clk_i);
        if (!cfg_ack_o) begin
            report_mismatch("cfg_ack_o", 32'h1, cfg_ack_o);
        end
        rdata     = cfg_dat_o;
        cfg_cyc_i = 1'b0;
        cfg_stb_i = 1'b0;
        cfg_we_i  = 1'b0;
    endtask

    task automatic cfg_write(input cfg_addr_t adr, input bus_data_t dat);
        bus_data_t unused;
        cfg_access(1'b1, adr, dat, unused);
    endtask

    task automatic cfg_read(input cfg_addr_t adr, output bus_data_t dat);
        cfg_access(1'b0, adr, '0, dat);
    endtask

    task automatic clear_logs();
        log_adr.delete();
        log_we.delete();
        log_sel.delete();
        log_dat.delete();
        tx_log.delete();
        rx_log.delete();
    endtask

    task automatic run_row(input int r);
        row_t        row;
        bus_data_t   rd;
        bus_data_t   w;
        bus_sel_t    exp_sel;
        logic [17:0] exp_wadr [$];
        logic [7:0]  exp_tx [$];
        row = table_q[r];
        // descriptor fields from msb down are last, length, increment and word address
        cfg_write(8'h80, {row.ndesc == 2'd1, row.l0, row.i0, row.a0});
        if (row.ndesc == 2'd2) begin
            cfg_write(8'h84, {1'b1, row.l1, row.i1, row.a1});
        end
        cfg_write(RUNS_ADR, '0);
        cfg_write(CTRL_ADR, {24'd0, row.lane, row.bmode, 1'b0, row.dir, row.ext, 2'b01});
        clear_logs();
        if (row.ext) begin
            @(negedge fast_clk_i);
            if (!dma_rdy_o) begin
                report_mismatch("dma_rdy_o", 32'h1, dma_rdy_o);
            end
            dma_req_i = 1'b1;
            while (dma_rdy_o) @(negedge fast_clk_i);
            dma_req_i = 1'b0;
            while (!dma_rdy_o) @(negedge fast_clk_i);
        end else begin
            cfg_write(TRIG_ADR, 32'h8);
            do begin
                cfg_read(CTRL_ADR, rd);
            end while (rd[1]);
        end

        // expected word addresses from the descriptors
        for (int c = 0; c <= int'(row.l0); c++) begin
            exp_wadr.push_back(row.i0 ? row.a0 + 18'(c) : row.a0);
        end
        if (row.ndesc == 2'd2) begin
            for (int c = 0; c <= int'(row.l1); c++) begin
                exp_wadr.push_back(row.i1 ? row.a1 + 18'(c) : row.a1);
            end
        end
        exp_sel = row.bmode ? bus_sel_t'(4'b0001 << row.lane) : 4'hF;

        if (log_adr.size() != int'(row.exp_xfers)) begin
            report_mismatch("memory access count", row.exp_xfers, log_adr.size());
        end
        for (int i = 0; i < log_adr.size() && i < exp_wadr.size(); i++) begin
            if (log_adr[i] != {exp_wadr[i], 2'b00}) begin
                report_mismatch("mem_adr_o", {exp_wadr[i], 2'b00}, log_adr[i]);
            end
            if (log_we[i] != row.dir) begin
                report_mismatch("mem_we_o", row.dir, log_we[i]);
            end
            if (log_sel[i] != exp_sel) begin
                report_mismatch("mem_sel_o", exp_sel, log_sel[i]);
            end
        end

        if (!row.dir) begin
            // to-stream bytes go lane 0 first and only one lane in byte mode
            foreach (exp_wadr[i]) begin
                w = model_word({exp_wadr[i], 2'b00});
                for (int b = 0; b < 4; b++) begin
                    if (!row.bmode || b == int'(row.lane)) begin
                        exp_tx.push_back(w[8*b +: 8]);
                    end
                end
            end
            if (tx_log.size() != int'(row.exp_bytes)) begin
                report_mismatch("tx byte count", row.exp_bytes, tx_log.size());
            end
            for (int i = 0; i < tx_log.size() && i < exp_tx.size(); i++) begin
                if (tx_log[i] != exp_tx[i]) begin
                    report_mismatch("tx_data_o", exp_tx[i], tx_log[i]);
                end
            end
        end else begin
            if (rx_log.size() != int'(row.exp_bytes)) begin
                report_mismatch("rx byte count", row.exp_bytes, rx_log.size());
            end
            for (int i = 0; i < log_dat.size(); i++) begin
                if (row.bmode && i < rx_log.size()) begin
                    if (log_dat[i][8*row.lane +: 8] != rx_log[i]) begin
                        report_mismatch("mem_dat_o lane", rx_log[i],
                                        log_dat[i][8*row.lane +: 8]);
                    end
                end else if (!row.bmode && 4*i + 3 < rx_log.size()) begin
                    w = {rx_log[4*i+3], rx_log[4*i+2], rx_log[4*i+1], rx_log[4*i]};
                    if (log_dat[i] != w) begin
                        report_mismatch("mem_dat_o", w, log_dat[i]);
                    end
                end
            end
        end

        cfg_read(RUNS_ADR, rd);
        if (rd != 32'd1) begin
            report_mismatch("run count", 32'd1, rd);
        end
        cfg_read(DESC_ADR, rd);
        if (rd != bus_data_t'(row.ndesc)) begin
            report_mismatch("descriptor index", bus_data_t'(row.ndesc), rd);
        end
    endtask

    initial begin
        bus_data_t rd;
        void'($urandom(64821));
        val_errs         = 0;
        misc_errs        = 0;
        cycles           = 0;
        ack_wait         = 1;
        rx_next          = 8'h3C;
        dma_engine_reset = 1'b1;
        cfg_cyc_i        = 1'b0;
        cfg_stb_i        = 1'b0;
        cfg_we_i         = 1'b0;
        cfg_adr_i        = '0;
        cfg_dat_i        = '0;
        cfg_sel_i        = '0;
        dma_req_i        = 1'b0;

        // dir, bmode, lane, ext, ndesc, desc 0, desc 1, transfers, bytes
        table_q[0] = '{1'b0, 1'b0, 2'd0, 1'b0, 2'd1, 18'h00100, 1'b1, 12'd3,
                       18'h0, 1'b0, 12'd0, 8'd4, 8'd16};
        table_q[1] = '{1'b1, 1'b1, 2'd2, 1'b0, 2'd1, 18'h00240, 1'b0, 12'd4,
                       18'h0, 1'b0, 12'd0, 8'd5, 8'd5};
        table_q[2] = '{1'b0, 1'b0, 2'd0, 1'b0, 2'd2, 18'h00300, 1'b1, 12'd1,
                       18'h00400, 1'b1, 12'd2, 8'd5, 8'd20};
        table_q[3] = '{1'b1, 1'b0, 2'd0, 1'b1, 2'd1, 18'h00500, 1'b1, 12'd2,
                       18'h0, 1'b0, 12'd0, 8'd3, 8'd12};
        table_q[4] = '{1'b0, 1'b1, 2'd3, 1'b0, 2'd1, 18'h3FFFE, 1'b1, 12'd2,
                       18'h0, 1'b0, 12'd0, 8'd3, 8'd3};

        repeat (8) @(negedge fast_clk_i);
        dma_engine_reset = 1'b0;

        // control word readback where bit 4 is not stored
        cfg_write(CTRL_ADR, 32'hFD);
        cfg_read(CTRL_ADR, rd);
        if (rd != 32'hED) begin
            report_mismatch("control word", 32'hED, rd);
        end
        cfg_write(CTRL_ADR, '0);

        for (int r = 0; r < ROWS; r++) begin
            run_row(r);
        end

        // the last row left a count of one, a write to its word clears it
        cfg_write(RUNS_ADR, 32'h5);
        cfg_read(RUNS_ADR, rd);
        if (rd != '0) begin
            report_mismatch("run count", 32'h0, rd);
        end

        // with enable clear neither trigger nor request may start a run
        cfg_write(CTRL_ADR, 32'h4);
        clear_logs();
        dma_req_i = 1'b1;
        cfg_write(TRIG_ADR, 32'h8);
        repeat (20) @(negedge fast_clk_i);
        dma_req_i = 1'b0;
        if (log_adr.size() != 0) begin
            misc_errs++;
            $display("memory access occurred with enable clear");
        end
        if (dma_rdy_o) begin
            report_mismatch("dma_rdy_o", 32'h0, dma_rdy_o);
        end

        $display("value errors: %0d, other errors: %0d", val_errs, misc_errs);
        if (val_errs == 0 && misc_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- sim/dma_tb_clk.sv
module dma_tb_clk (
    output logic fast_clk_o
);
    // period of 40, high and low for 20 each
    initial begin
        fast_clk_o = 1'b0;
    end

    always begin
        #20;
        fast_clk_o = ~fast_clk_o;
    end

endmodule

//--- tb.f
+incdir+logic
logic/dma_bus_pkg.sv
logic/dma_desc_pkg.sv
logic/dma_ctrl_if.sv
logic/dma_lane_if.sv
logic/dma_reg_decode.sv
logic/dma_sequencer.sv
logic/dma_byte_packer.sv
logic/spi_dma_top.sv
sim/dma_tb_clk.sv
sim/dma_chk.sv
sim/dma_tb.sv
